/* hdl/ex_pkg.sv */
package ex_pkg;

    localparam int unsigned XLEN       = 32;
    localparam int unsigned REG_ADDR_W = 5;
    localparam int unsigned TIMER_W    = 64;

    // execute opcodes, listed by result group
    typedef enum logic [5:0] {
        OP_ADD, OP_SUB, OP_SLT, OP_SLTU,
        OP_AND, OP_OR, OP_NOR, OP_XOR,
        OP_SLL, OP_SRL, OP_SRA,
        OP_MUL, OP_MULH, OP_MULHU, OP_DIV, OP_DIVU, OP_MOD, OP_MODU,
        OP_LUI, OP_PCADDU,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU, OP_JIRL,
        OP_LD_B, OP_LD_H, OP_LD_W, OP_ST_B, OP_ST_H, OP_ST_W,
        OP_CSRWR, OP_CSRXCHG, OP_CSRRD, OP_RDCNTVL, OP_RDCNTVH,
        OP_NOP
    } ex_op_e;

    // source of the write-back value
    typedef enum logic [2:0] {
        GRP_ARITH, GRP_LOGIC, GRP_SHIFT, GRP_MOVE, GRP_JUMP, GRP_CSR, GRP_NONE
    } res_grp_e;

    function automatic res_grp_e op_group(input ex_op_e op);
        case (op)
            OP_ADD, OP_SUB, OP_SLT, OP_SLTU,
            OP_MUL, OP_MULH, OP_MULHU,
            OP_DIV, OP_DIVU, OP_MOD, OP_MODU:                   return GRP_ARITH;
            OP_AND, OP_OR, OP_NOR, OP_XOR:                      return GRP_LOGIC;
            OP_SLL, OP_SRL, OP_SRA:                             return GRP_SHIFT;
            OP_LUI, OP_PCADDU:                                  return GRP_MOVE;
            OP_JIRL:                                            return GRP_JUMP;
            OP_CSRWR, OP_CSRXCHG, OP_CSRRD, OP_RDCNTVL, OP_RDCNTVH: return GRP_CSR;
            // conditional branches, memory ops and nop write nothing here
            default:                                            return GRP_NONE;
        endcase
    endfunction

    function automatic logic is_load(input ex_op_e op);
        return (op == OP_LD_B) || (op == OP_LD_H) || (op == OP_LD_W);
    endfunction

    function automatic logic is_store(input ex_op_e op);
        return (op == OP_ST_B) || (op == OP_ST_H) || (op == OP_ST_W);
    endfunction

    // access size: 0 byte, 1 halfword, 2 word
    function automatic logic [1:0] mem_size(input ex_op_e op);
        case (op)
            OP_LD_H, OP_ST_H: return 2'd1;
            OP_LD_W, OP_ST_W: return 2'd2;
            default:          return 2'd0;
        endcase
    endfunction

    function automatic logic csr_writes(input ex_op_e op);
        return (op == OP_CSRWR) || (op == OP_CSRXCHG);
    endfunction

endpackage

/* hdl/alu.sv */
`timescale 1ns/1ps

module alu (
    input  ex_pkg::ex_op_e          op_i,
    input  logic [ex_pkg::XLEN-1:0] pc_i,
    input  logic [ex_pkg::XLEN-1:0] src1_i,
    input  logic [ex_pkg::XLEN-1:0] src2_i,
    input  logic [ex_pkg::XLEN-1:0] imm_i,
    output logic [ex_pkg::XLEN-1:0] logic_o,
    output logic [ex_pkg::XLEN-1:0] shift_o,
    output logic                    taken_o,
    output logic [ex_pkg::XLEN-1:0] target_o
);

    logic [4:0] shamt;
    logic       eq;
    logic       lt_s;
    logic       lt_u;

    // only the low five bits count as shift amount
    assign shamt = src2_i[4:0];

    assign eq   = (src1_i == src2_i);
    assign lt_s = ($signed(src1_i) < $signed(src2_i));
    assign lt_u = (src1_i < src2_i);

    always_comb begin
        case (op_i)
            ex_pkg::OP_AND: logic_o = src1_i & src2_i;
            ex_pkg::OP_OR:  logic_o = src1_i | src2_i;
            ex_pkg::OP_NOR: logic_o = ~(src1_i | src2_i);
            ex_pkg::OP_XOR: logic_o = src1_i ^ src2_i;
            default:        logic_o = '0;
        endcase
    end

    always_comb begin
        case (op_i)
            ex_pkg::OP_SLL: shift_o = src1_i << shamt;
            ex_pkg::OP_SRL: shift_o = src1_i >> shamt;
            ex_pkg::OP_SRA: shift_o = $unsigned($signed(src1_i) >>> shamt);
            default:        shift_o = '0;
        endcase
    end

    // branch condition, jirl is unconditional
    always_comb begin
        case (op_i)
            ex_pkg::OP_BEQ:  taken_o = eq;
            ex_pkg::OP_BNE:  taken_o = !eq;
            ex_pkg::OP_BLT:  taken_o = lt_s;
            ex_pkg::OP_BGE:  taken_o = !lt_s;
            ex_pkg::OP_BLTU: taken_o = lt_u;
            ex_pkg::OP_BGEU: taken_o = !lt_u;
            ex_pkg::OP_JIRL: taken_o = 1'b1;
            default:         taken_o = 1'b0;
        endcase
    end

    // jirl is register relative, the rest pc relative
    assign target_o = (op_i == ex_pkg::OP_JIRL) ? (src1_i + imm_i) : (pc_i + imm_i);

endmodule

/* hdl/arith_unit.sv */
`timescale 1ns/1ps

module arith_unit (
    input  ex_pkg::ex_op_e          op_i,
    input  logic [ex_pkg::XLEN-1:0] src1_i,
    input  logic [ex_pkg::XLEN-1:0] src2_i,
    output logic [ex_pkg::XLEN-1:0] result_o
);

    localparam logic [ex_pkg::XLEN-1:0] MIN_S = {1'b1, {(ex_pkg::XLEN-1){1'b0}}};
    localparam logic [ex_pkg::XLEN-1:0] ONE   = {{(ex_pkg::XLEN-1){1'b0}}, 1'b1};

    logic [2*ex_pkg::XLEN-1:0] prod_s;
    logic [2*ex_pkg::XLEN-1:0] prod_u;
    logic                      lt_s;
    logic                      lt_u;
    logic                      div_zero;
    logic                      div_ovf;
    logic [ex_pkg::XLEN-1:0]   divisor_s;
    logic [ex_pkg::XLEN-1:0]   divisor_u;
    logic [ex_pkg::XLEN-1:0]   quot_s;
    logic [ex_pkg::XLEN-1:0]   rem_s;
    logic [ex_pkg::XLEN-1:0]   quot_u;
    logic [ex_pkg::XLEN-1:0]   rem_u;

    // full width products, operands extended to 64 bits
    assign prod_s = $signed(src1_i) * $signed(src2_i);
    assign prod_u = src1_i * src2_i;

    assign lt_s = ($signed(src1_i) < $signed(src2_i));
    assign lt_u = (src1_i < src2_i);

    assign div_zero = (src2_i == '0);
    assign div_ovf  = (src1_i == MIN_S) && (src2_i == '1);

    // divide by one in the corner cases
    // quotient is then src1, remainder zero
    assign divisor_s = (div_zero || div_ovf) ? ONE : src2_i;
    assign divisor_u = div_zero ? ONE : src2_i;

    assign quot_s = $unsigned($signed(src1_i) / $signed(divisor_s));
    assign rem_s  = $unsigned($signed(src1_i) % $signed(divisor_s));
    assign quot_u = src1_i / divisor_u;
    assign rem_u  = src1_i % divisor_u;

    always_comb begin
        case (op_i)
            ex_pkg::OP_ADD:   result_o = src1_i + src2_i;
            ex_pkg::OP_SUB:   result_o = src1_i - src2_i;
            ex_pkg::OP_SLT:   result_o = {{(ex_pkg::XLEN-1){1'b0}}, lt_s};
            ex_pkg::OP_SLTU:  result_o = {{(ex_pkg::XLEN-1){1'b0}}, lt_u};
            ex_pkg::OP_MUL:   result_o = prod_s[ex_pkg::XLEN-1:0];
            ex_pkg::OP_MULH:  result_o = prod_s[2*ex_pkg::XLEN-1:ex_pkg::XLEN];
            ex_pkg::OP_MULHU: result_o = prod_u[2*ex_pkg::XLEN-1:ex_pkg::XLEN];
            ex_pkg::OP_DIV:   result_o = quot_s;
            ex_pkg::OP_DIVU:  result_o = quot_u;
            // modulo by zero passes the dividend through
            ex_pkg::OP_MOD:   result_o = div_zero ? src1_i : rem_s;
            ex_pkg::OP_MODU:  result_o = div_zero ? src1_i : rem_u;
            default:          result_o = '0;
        endcase
    end

endmodule

/* hdl/ex.sv */
`timescale 1ns/1ps

module ex (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_valid_i,
    input  ex_pkg::ex_op_e                op_i,
    input  logic [ex_pkg::XLEN-1:0]       pc_i,
    input  logic [ex_pkg::XLEN-1:0]       src1_i,
    input  logic [ex_pkg::XLEN-1:0]       src2_i,
    input  logic [ex_pkg::XLEN-1:0]       imm_i,
    input  logic                          use_imm_i,
    input  logic [ex_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic                          wreg_i,
    input  logic                          predicted_taken_i,
    input  logic [ex_pkg::XLEN-1:0]       csr_rdata_i,
    input  logic [ex_pkg::TIMER_W-1:0]    timer_i,
    input  logic                          flush_i,
    output logic                          out_valid_o,
    output logic [ex_pkg::XLEN-1:0]       wdata_o,
    output logic [ex_pkg::REG_ADDR_W-1:0] waddr_o,
    output logic                          wreg_o,
    output logic [ex_pkg::XLEN-1:0]       mem_addr_o,
    output logic [ex_pkg::XLEN-1:0]       mem_store_data_o,
    output logic                          mem_load_o,
    output logic                          mem_store_o,
    output logic [1:0]                    mem_size_o,
    output logic                          excp_ale_o,
    output logic                          csr_we_o,
    output logic [ex_pkg::XLEN-1:0]       csr_wdata_o,
    output logic                          redirect_o,
    output logic [ex_pkg::XLEN-1:0]       redirect_target_o
);

    logic [ex_pkg::XLEN-1:0] src2_eff;
    logic [ex_pkg::XLEN-1:0] logic_res;
    logic [ex_pkg::XLEN-1:0] shift_res;
    logic [ex_pkg::XLEN-1:0] arith_res;
    logic [ex_pkg::XLEN-1:0] br_target;
    logic                    br_taken;
    ex_pkg::res_grp_e        grp;
    logic [ex_pkg::XLEN-1:0] wdata_d;
    logic [ex_pkg::XLEN-1:0] mem_addr_d;
    logic [ex_pkg::XLEN-1:0] csr_wdata_d;
    logic [1:0]              size_d;
    logic                    ld_d;
    logic                    st_d;
    logic                    ale_d;

    assign src2_eff = use_imm_i ? imm_i : src2_i;
    assign grp      = ex_pkg::op_group(op_i);

    alu u_alu (
        .op_i     (op_i),
        .pc_i     (pc_i),
        .src1_i   (src1_i),
        .src2_i   (src2_eff),
        .imm_i    (imm_i),
        .logic_o  (logic_res),
        .shift_o  (shift_res),
        .taken_o  (br_taken),
        .target_o (br_target)
    );

    arith_unit u_arith (
        .op_i     (op_i),
        .src1_i   (src1_i),
        .src2_i   (src2_eff),
        .result_o (arith_res)
    );

    // memory access and alignment check
    assign mem_addr_d = src1_i + imm_i;
    assign size_d     = ex_pkg::mem_size(op_i);
    assign ld_d       = ex_pkg::is_load(op_i);
    assign st_d       = ex_pkg::is_store(op_i);
    assign ale_d      = (ld_d || st_d) &&
                        (((size_d == 2'd1) && mem_addr_d[0]) ||
                         ((size_d == 2'd2) && (mem_addr_d[1:0] != 2'b00)));

    // csrxchg writes only the bits selected by the src2 mask
    assign csr_wdata_d = (op_i == ex_pkg::OP_CSRXCHG) ?
                         ((src1_i & src2_i) | (csr_rdata_i & ~src2_i)) : src1_i;

    always_comb begin
        case (grp)
            ex_pkg::GRP_ARITH: wdata_d = arith_res;
            ex_pkg::GRP_LOGIC: wdata_d = logic_res;
            ex_pkg::GRP_SHIFT: wdata_d = shift_res;
            ex_pkg::GRP_MOVE:  wdata_d = (op_i == ex_pkg::OP_PCADDU) ? (src2_eff + pc_i) : src2_eff;
            ex_pkg::GRP_JUMP:  wdata_d = pc_i + 32'd4;
            ex_pkg::GRP_CSR: begin
                case (op_i)
                    ex_pkg::OP_RDCNTVL: wdata_d = timer_i[ex_pkg::XLEN-1:0];
                    ex_pkg::OP_RDCNTVH: wdata_d = timer_i[ex_pkg::TIMER_W-1:ex_pkg::XLEN];
                    default:            wdata_d = csr_rdata_i;
                endcase
            end
            default:           wdata_d = '0;
        endcase
    end

    // control flags, cleared by reset and flush
    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            out_valid_o <= 1'b0;
            wreg_o      <= 1'b0;
            mem_load_o  <= 1'b0;
            mem_store_o <= 1'b0;
            excp_ale_o  <= 1'b0;
            csr_we_o    <= 1'b0;
            redirect_o  <= 1'b0;
        end else begin
            out_valid_o <= in_valid_i;
            wreg_o      <= in_valid_i && wreg_i;
            mem_load_o  <= in_valid_i && ld_d && !ale_d;
            mem_store_o <= in_valid_i && st_d && !ale_d;
            excp_ale_o  <= in_valid_i && ale_d;
            csr_we_o    <= in_valid_i && ex_pkg::csr_writes(op_i);
            // only a taken branch the frontend missed needs a redirect
            redirect_o  <= in_valid_i && br_taken && !predicted_taken_i;
        end
    end

    // payload, loaded with each accepted instruction
    always_ff @(posedge clk) begin
        if (in_valid_i) begin
            wdata_o           <= wdata_d;
            waddr_o           <= waddr_i;
            mem_addr_o        <= mem_addr_d;
            mem_store_data_o  <= src2_i;
            mem_size_o        <= size_d;
            csr_wdata_o       <= csr_wdata_d;
            redirect_target_o <= br_target;
        end
    end

endmodule

/* hdl/ex_top.sv */
`timescale 1ns/1ps

module ex_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_valid_i,
    input  ex_pkg::ex_op_e                op_i,
    input  logic [ex_pkg::XLEN-1:0]       pc_i,
    input  logic [ex_pkg::XLEN-1:0]       src1_i,
    input  logic [ex_pkg::XLEN-1:0]       src2_i,
    input  logic [ex_pkg::XLEN-1:0]       imm_i,
    input  logic                          use_imm_i,
    input  logic [ex_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic                          wreg_i,
    input  logic                          predicted_taken_i,
    input  logic [ex_pkg::XLEN-1:0]       csr_rdata_i,
    input  logic [ex_pkg::TIMER_W-1:0]    timer_i,
    input  logic                          flush_i,
    output logic                          out_valid_o,
    output logic [ex_pkg::XLEN-1:0]       wdata_o,
    output logic [ex_pkg::REG_ADDR_W-1:0] waddr_o,
    output logic                          wreg_o,
    output logic [ex_pkg::XLEN-1:0]       mem_addr_o,
    output logic [ex_pkg::XLEN-1:0]       mem_store_data_o,
    output logic                          mem_load_o,
    output logic                          mem_store_o,
    output logic [1:0]                    mem_size_o,
    output logic                          excp_ale_o,
    output logic                          csr_we_o,
    output logic [ex_pkg::XLEN-1:0]       csr_wdata_o,
    output logic                          redirect_o,
    output logic [ex_pkg::XLEN-1:0]       redirect_target_o
);

    ex u_ex (
        .clk               (clk),
        .rst               (rst),
        .in_valid_i        (in_valid_i),
        .op_i              (op_i),
        .pc_i              (pc_i),
        .src1_i            (src1_i),
        .src2_i            (src2_i),
        .imm_i             (imm_i),
        .use_imm_i         (use_imm_i),
        .waddr_i           (waddr_i),
        .wreg_i            (wreg_i),
        .predicted_taken_i (predicted_taken_i),
        .csr_rdata_i       (csr_rdata_i),
        .timer_i           (timer_i),
        .flush_i           (flush_i),
        .out_valid_o       (out_valid_o),
        .wdata_o           (wdata_o),
        .waddr_o           (waddr_o),
        .wreg_o            (wreg_o),
        .mem_addr_o        (mem_addr_o),
        .mem_store_data_o  (mem_store_data_o),
        .mem_load_o        (mem_load_o),
        .mem_store_o       (mem_store_o),
        .mem_size_o        (mem_size_o),
        .excp_ale_o        (excp_ale_o),
        .csr_we_o          (csr_we_o),
        .csr_wdata_o       (csr_wdata_o),
        .redirect_o        (redirect_o),
        .redirect_target_o (redirect_target_o)
    );

endmodule

/* tests/tb_ex_ref.svh */
typedef logic [ex_pkg::XLEN-1:0] word_t;

// expected outputs of one instruction
typedef struct packed {
    ex_pkg::ex_op_e                op;
    word_t                         wdata;
    logic [ex_pkg::REG_ADDR_W-1:0] waddr;
    logic                          wreg;
    word_t                         addr;
    word_t                         st_data;
    logic                          load;
    logic                          store;
    logic [1:0]                    size;
    logic                          ale;
    logic                          csr_we;
    word_t                         csr_wdata;
    logic                          redirect;
    word_t                         target;
} exp_t;

logic [31:0] lfsr = 32'd72;

// fibonacci lfsr with taps 32 22 2 1, one step per bit taken
function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        r    = {r[30:0], fb};
    end
    return r;
endfunction

function automatic exp_t ex_ref(
    input ex_pkg::ex_op_e                op,
    input word_t                         pc,
    input word_t                         s1,
    input word_t                         s2,
    input word_t                         imm,
    input logic                          use_imm,
    input logic [ex_pkg::REG_ADDR_W-1:0] waddr,
    input logic                          wreg,
    input logic                          pred,
    input word_t                         csr,
    input logic [ex_pkg::TIMER_W-1:0]    timer
);
    exp_t                      e;
    word_t                     b;
    word_t                     qs;
    word_t                     rs;
    word_t                     cw;
    logic [2*ex_pkg::XLEN-1:0] ps;
    logic [2*ex_pkg::XLEN-1:0] pu;
    logic                      taken;
    e  = '0;
    b  = use_imm ? imm : s2;
    ps = {{ex_pkg::XLEN{s1[ex_pkg::XLEN-1]}}, s1} * {{ex_pkg::XLEN{b[ex_pkg::XLEN-1]}}, b};
    pu = {{ex_pkg::XLEN{1'b0}}, s1} * {{ex_pkg::XLEN{1'b0}}, b};
    // zero divisor returns the dividend, min / -1 gives min rem 0
    if (b == '0) begin
        qs = s1;
        rs = s1;
    end else if ((s1 == {1'b1, {(ex_pkg::XLEN-1){1'b0}}}) && (b == '1)) begin
        qs = s1;
        rs = '0;
    end else begin
        qs = $signed(s1) / $signed(b);
        rs = $signed(s1) % $signed(b);
    end
    case (op)
        ex_pkg::OP_ADD:     e.wdata = s1 + b;
        ex_pkg::OP_SUB:     e.wdata = s1 - b;
        ex_pkg::OP_SLT:     e.wdata = ($signed(s1) < $signed(b)) ? 1 : 0;
        ex_pkg::OP_SLTU:    e.wdata = (s1 < b) ? 1 : 0;
        ex_pkg::OP_AND:     e.wdata = s1 & b;
        ex_pkg::OP_OR:      e.wdata = s1 | b;
        ex_pkg::OP_NOR:     e.wdata = ~(s1 | b);
        ex_pkg::OP_XOR:     e.wdata = s1 ^ b;
        ex_pkg::OP_SLL:     e.wdata = s1 << b[4:0];
        ex_pkg::OP_SRL:     e.wdata = s1 >> b[4:0];
        ex_pkg::OP_SRA:     e.wdata = $signed(s1) >>> b[4:0];
        ex_pkg::OP_MUL:     e.wdata = ps[ex_pkg::XLEN-1:0];
        ex_pkg::OP_MULH:    e.wdata = ps[2*ex_pkg::XLEN-1:ex_pkg::XLEN];
        ex_pkg::OP_MULHU:   e.wdata = pu[2*ex_pkg::XLEN-1:ex_pkg::XLEN];
        ex_pkg::OP_DIV:     e.wdata = qs;
        ex_pkg::OP_MOD:     e.wdata = rs;
        ex_pkg::OP_DIVU:    e.wdata = (b == '0) ? s1 : s1 / b;
        ex_pkg::OP_MODU:    e.wdata = (b == '0) ? s1 : s1 % b;
        ex_pkg::OP_LUI:     e.wdata = b;
        ex_pkg::OP_PCADDU:  e.wdata = b + pc;
        ex_pkg::OP_JIRL:    e.wdata = pc + 4;
        ex_pkg::OP_RDCNTVL: e.wdata = timer[ex_pkg::XLEN-1:0];
        ex_pkg::OP_RDCNTVH: e.wdata = timer[2*ex_pkg::XLEN-1:ex_pkg::XLEN];
        ex_pkg::OP_CSRWR, ex_pkg::OP_CSRXCHG, ex_pkg::OP_CSRRD: e.wdata = csr;
        default:            e.wdata = '0;
    endcase
    case (op)
        ex_pkg::OP_BEQ:  taken = (s1 == b);
        ex_pkg::OP_BNE:  taken = (s1 != b);
        ex_pkg::OP_BLT:  taken = ($signed(s1) < $signed(b));
        ex_pkg::OP_BGE:  taken = ($signed(s1) >= $signed(b));
        ex_pkg::OP_BLTU: taken = (s1 < b);
        ex_pkg::OP_BGEU: taken = (s1 >= b);
        ex_pkg::OP_JIRL: taken = 1'b1;
        default:         taken = 1'b0;
    endcase
    e.op       = op;
    e.waddr    = waddr;
    e.wreg     = wreg;
    e.redirect = taken && !pred;
    e.target   = (op == ex_pkg::OP_JIRL) ? s1 + imm : pc + imm;
    // memory access, misaligned ones are not issued
    e.addr    = s1 + imm;
    e.st_data = s2;
    if ((op == ex_pkg::OP_LD_H) || (op == ex_pkg::OP_ST_H)) begin
        e.size = 2'd1;
    end else if ((op == ex_pkg::OP_LD_W) || (op == ex_pkg::OP_ST_W)) begin
        e.size = 2'd2;
    end
    e.load  = (op == ex_pkg::OP_LD_B) || (op == ex_pkg::OP_LD_H) || (op == ex_pkg::OP_LD_W);
    e.store = (op == ex_pkg::OP_ST_B) || (op == ex_pkg::OP_ST_H) || (op == ex_pkg::OP_ST_W);
    // an access must sit on a multiple of its own byte count
    e.ale   = (e.load || e.store) && ((e.addr % (1 << e.size)) != 0);
    e.load  = e.load && !e.ale;
    e.store = e.store && !e.ale;
    // csrxchg takes src1 only where the src2 mask is set
    for (int i = 0; i < ex_pkg::XLEN; i++) begin
        cw[i] = ((op == ex_pkg::OP_CSRXCHG) && !s2[i]) ? csr[i] : s1[i];
    end
    e.csr_we    = (op == ex_pkg::OP_CSRWR) || (op == ex_pkg::OP_CSRXCHG);
    e.csr_wdata = cw;
    return e;
endfunction

/* tests/tb_ex_top.sv */
`timescale 1ns/1ps

module tb_ex_top;

    localparam int unsigned N_CALC   = 40;
    localparam int unsigned N_ISSUE  = N_CALC + 6 + 28 + 24 + 10 + 2;
    // one cycle per instruction, plus reset, drain cycles and slack
    localparam int unsigned LIMIT_NS = (N_ISSUE + 120) * 20;

    logic                          clk;
    logic                          rst;
    logic                          in_valid_i;
    ex_pkg::ex_op_e                op_i;
    logic [ex_pkg::XLEN-1:0]       pc_i;
    logic [ex_pkg::XLEN-1:0]       src1_i;
    logic [ex_pkg::XLEN-1:0]       src2_i;
    logic [ex_pkg::XLEN-1:0]       imm_i;
    logic                          use_imm_i;
    logic [ex_pkg::REG_ADDR_W-1:0] waddr_i;
    logic                          wreg_i;
    logic                          predicted_taken_i;
    logic [ex_pkg::XLEN-1:0]       csr_rdata_i;
    logic [ex_pkg::TIMER_W-1:0]    timer_i;
    logic                          flush_i;
    logic                          out_valid_o;
    logic [ex_pkg::XLEN-1:0]       wdata_o;
    logic [ex_pkg::REG_ADDR_W-1:0] waddr_o;
    logic                          wreg_o;
    logic [ex_pkg::XLEN-1:0]       mem_addr_o;
    logic [ex_pkg::XLEN-1:0]       mem_store_data_o;
    logic                          mem_load_o;
    logic                          mem_store_o;
    logic [1:0]                    mem_size_o;
    logic                          excp_ale_o;
    logic                          csr_we_o;
    logic [ex_pkg::XLEN-1:0]       csr_wdata_o;
    logic                          redirect_o;
    logic [ex_pkg::XLEN-1:0]       redirect_target_o;

    `include "tb_ex_ref.svh"

    exp_t           exp_q[$];
    int unsigned    cyc_q[$];
    int unsigned    cycle = 0;
    int             errors = 0;
    int             err_mark = 0;
    int             tests_ok = 0;
    int             tests_bad = 0;

    ex_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cycle++;

    task automatic check_word(input string name, input ex_pkg::ex_op_e op,
                              input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Mismatch %s (%s): got %h expected %h", name, op.name(), got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input ex_pkg::ex_op_e op,
                             input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch %s (%s): got %h expected %h", name, op.name(), got, exp);
            errors++;
        end
    endtask

    task automatic rand_fields();
        pc_i              = rand_bits(32) & 32'hffff_fffc;
        src1_i            = rand_bits(32);
        src2_i            = rand_bits(32);
        imm_i             = rand_bits(32);
        use_imm_i         = 1'(rand_bits(1));
        waddr_i           = 5'(rand_bits(5));
        wreg_i            = 1'(rand_bits(1));
        predicted_taken_i = 1'(rand_bits(1));
        csr_rdata_i       = rand_bits(32);
        timer_i           = {rand_bits(32), rand_bits(32)};
    endtask

    // strobe the fields now on the inputs for one cycle
    task automatic send();
        exp_q.push_back(ex_ref(op_i, pc_i, src1_i, src2_i, imm_i, use_imm_i, waddr_i,
                               wreg_i, predicted_taken_i, csr_rdata_i, timer_i));
        cyc_q.push_back(cycle);
        in_valid_i = 1'b1;
        @(posedge clk);
        #2;
        in_valid_i = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        // idle cycles so a stray output still lands in this test
        repeat (2) @(posedge clk);
        #2;
    endtask

    task automatic finish_test(input string name);
        drain();
        if (errors == err_mark) begin
            tests_ok++;
            $display("test %s: passed", name);
        end else begin
            tests_bad++;
            $display("test %s: failed with %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    // outputs settle after the rising edge, so compare on the falling one
    initial begin
        exp_t        e;
        int unsigned issued;
        forever begin
            @(negedge clk);
            if (out_valid_o === 1'b1) begin
                if (exp_q.size() == 0) begin
                    $display("out_valid_o went high with no instruction outstanding");
                    errors++;
                end else begin
                    e = exp_q.pop_front();
                    issued = cyc_q.pop_front();
                    if (cycle != issued + 1) begin
                        $display("%s result arrived %0d cycles after its strobe instead of 1",
                                 e.op.name(), cycle - issued);
                        errors++;
                    end
                    check_word("wdata_o", e.op, wdata_o, e.wdata);
                    check_word("waddr_o", e.op, waddr_o, e.waddr);
                    check_bit("wreg_o", e.op, wreg_o, e.wreg);
                    check_word("mem_addr_o", e.op, mem_addr_o, e.addr);
                    check_word("mem_store_data_o", e.op, mem_store_data_o, e.st_data);
                    check_bit("mem_load_o", e.op, mem_load_o, e.load);
                    check_bit("mem_store_o", e.op, mem_store_o, e.store);
                    check_word("mem_size_o", e.op, mem_size_o, e.size);
                    check_bit("excp_ale_o", e.op, excp_ale_o, e.ale);
                    check_bit("csr_we_o", e.op, csr_we_o, e.csr_we);
                    check_word("csr_wdata_o", e.op, csr_wdata_o, e.csr_wdata);
                    check_bit("redirect_o", e.op, redirect_o, e.redirect);
                    check_word("redirect_target_o", e.op, redirect_target_o, e.target);
                end
            end
        end
    end

    initial begin
        #(LIMIT_NS);
        $display("watchdog expired before all results arrived");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        rst     = 1'b1;
        flush_i = 1'b0;
        rand_fields();
        // strobes during reset must not reach the outputs
        in_valid_i        = 1'b1;
        wreg_i            = 1'b1;
        predicted_taken_i = 1'b0;
        src1_i[1:0]       = 2'b00;
        imm_i[1:0]        = 2'b00;
        op_i              = ex_pkg::OP_JIRL;
        for (int k = 0; k < 3; k++) begin
            @(posedge clk);
            #2;
            if (k == 0) begin
                op_i = ex_pkg::OP_LD_W;
            end else if (k == 1) begin
                op_i = ex_pkg::OP_CSRWR;
            end else begin
                rst        = 1'b0;
                in_valid_i = 1'b0;
                op_i       = ex_pkg::OP_NOP;
            end
            @(negedge clk);
            check_bit("out_valid_o", ex_pkg::OP_NOP, out_valid_o, 1'b0);
            check_bit("wreg_o", ex_pkg::OP_NOP, wreg_o, 1'b0);
            check_bit("mem_load_o", ex_pkg::OP_NOP, mem_load_o, 1'b0);
            check_bit("mem_store_o", ex_pkg::OP_NOP, mem_store_o, 1'b0);
            check_bit("csr_we_o", ex_pkg::OP_NOP, csr_we_o, 1'b0);
            check_bit("excp_ale_o", ex_pkg::OP_NOP, excp_ale_o, 1'b0);
            check_bit("redirect_o", ex_pkg::OP_NOP, redirect_o, 1'b0);
        end
        @(posedge clk);
        #2;
        finish_test("reset state");

        // the first 18 opcodes are the compute ops
        for (int k = 0; k < N_CALC; k++) begin
            rand_fields();
            op_i = ex_pkg::ex_op_e'(ex_pkg::OP_ADD + rand_bits(8) % 18);
            send();
        end
        // zero divisors, then min / -1
        for (int k = 0; k < 6; k++) begin
            rand_fields();
            use_imm_i = 1'b0;
            op_i      = ex_pkg::ex_op_e'(ex_pkg::OP_DIV + k % 4);
            src2_i    = '0;
            if (k >= 4) begin
                op_i   = (k == 4) ? ex_pkg::OP_DIV : ex_pkg::OP_MOD;
                src1_i = 32'h8000_0000;
                src2_i = '1;
            end
            send();
        end
        finish_test("compute ops back-to-back");

        for (int k = 0; k < 28; k++) begin
            rand_fields();
            op_i              = ex_pkg::ex_op_e'(ex_pkg::OP_BEQ + k % 7);
            use_imm_i         = 1'b0;
            predicted_taken_i = 1'((k / 7) % 2);
            // equal operands now and then
            if (rand_bits(2) == 0) begin
                src2_i = src1_i;
            end
            send();
        end
        finish_test("branches and jirl");

        for (int k = 0; k < 24; k++) begin
            rand_fields();
            op_i        = ex_pkg::ex_op_e'(ex_pkg::OP_LD_B + k / 4);
            src1_i[1:0] = 2'b00;
            imm_i[1:0]  = 2'(k % 4);
            send();
        end
        finish_test("loads and stores at every alignment");

        for (int k = 0; k < 10; k++) begin
            rand_fields();
            op_i = ex_pkg::ex_op_e'(ex_pkg::OP_CSRWR + k % 5);
            send();
        end
        finish_test("csr and timer reads");

        rand_fields();
        op_i       = ex_pkg::OP_SUB;
        in_valid_i = 1'b1;
        flush_i    = 1'b1;
        @(posedge clk);
        #2;
        flush_i = 1'b0;
        rand_fields();
        op_i = ex_pkg::OP_ADD;
        send();
        finish_test("flush with strobe");

        $display("tests passed %0d, failed %0d, check errors %0d", tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* ex_top.f */
+incdir+tests
hdl/ex_pkg.sv
hdl/alu.sv
hdl/arith_unit.sv
hdl/ex.sv
hdl/ex_top.sv
tests/tb_ex_top.sv

/* Bender.yml */
package:
  name: ex_top

sources:
  - hdl/ex_pkg.sv
  - hdl/alu.sv
  - hdl/arith_unit.sv
  - hdl/ex.sv
  - hdl/ex_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_ex_top.sv
